// ==== common/mul_settings.svh ====
// width and function code macros shared by the fast multiplier, include where needed.
`ifndef MUL_SETTINGS_SVH
`define MUL_SETTINGS_SVH

`define MUL_XLEN   32   // operand width.
`define MUL_PROD_W 64   // full product width.
`define MUL_ROWS   20   // partial product rows after padding.

// function codes as seen on fmul_func.
`define MUL_FUNC_MUL    4'd0
`define MUL_FUNC_MULH   4'd1
`define MUL_FUNC_MULHU  4'd2
`define MUL_FUNC_MULHSU 4'd3
`define MUL_FUNC_MULW   4'd8

`endif

// ==== common/mul_pkg.sv ====
// types shared by the fast multiplier blocks, imported by each module that uses them.
`default_nettype none

`include "mul_settings.svh"

package mul_pkg;

    typedef enum logic [3:0] {
        FUNC_MUL    = `MUL_FUNC_MUL,
        FUNC_MULH   = `MUL_FUNC_MULH,
        FUNC_MULHU  = `MUL_FUNC_MULHU,
        FUNC_MULHSU = `MUL_FUNC_MULHSU,
        FUNC_MULW   = `MUL_FUNC_MULW
    } mul_func_e;

    // request stage, operands already prepared for the booth array.
    typedef struct packed {
        logic                 valid;
        logic                 high_product;
        logic                 signed_op;    // MULH only.
        logic                 hsu_fix;      // MULHSU with negative op0.
        logic [`MUL_XLEN-1:0] op0;
        logic [`MUL_XLEN-1:0] op0_neg;
        logic [`MUL_XLEN-1:0] op1;
    } mreq_t;

    typedef struct packed {
        logic high_product;
        logic hsu_fix;
    } m1_ctrl_t;

    typedef logic [`MUL_ROWS-1:0][`MUL_PROD_W-1:0] pp_rows_t;

    typedef struct packed {
        logic [`MUL_PROD_W-1:0] sum;
        logic [`MUL_PROD_W-1:0] carry;  // already at its own weight.
    } csa_pair_t;

endpackage

`default_nettype wire

// ==== fastmul/mul_ctrl.sv ====
// request decode and operand setup for the fast multiplier, owns both stage enables.
`timescale 1ns/1ps
`default_nettype none

`include "mul_settings.svh"

module mul_ctrl (
    input  wire logic                 core_clk,
    input  wire logic                 core_reset_n,
    input  wire logic                 fmul_req,
    input  wire mul_pkg::mul_func_e   fmul_func,
    input  wire logic [`MUL_XLEN-1:0] fmul_op0,
    input  wire logic [`MUL_XLEN-1:0] fmul_op1,
    input  wire logic                 fmul_stall,
    output mul_pkg::mreq_t            mreq,
    output mul_pkg::m1_ctrl_t         m1_ctrl,
    output logic                      m1_load
);
    import mul_pkg::*;

    logic                 load_req;
    logic                 high_nx;
    logic                 signed_nx;
    logic                 hsu_nx;
    logic [`MUL_XLEN-1:0] op0_nx;
    logic                 valid_q;
    logic                 high_q;
    logic                 signed_q;
    logic                 hsu_q;
    logic [`MUL_XLEN-1:0] op0_q;
    logic [`MUL_XLEN-1:0] op0_neg_q;
    logic [`MUL_XLEN-1:0] op1_q;
    m1_ctrl_t             m1_ctrl_q;

    assign load_req = fmul_req & ~fmul_stall;
    assign m1_load  = valid_q & ~fmul_stall;

    always_comb begin
        high_nx   = 1'b0;
        signed_nx = 1'b0;
        case (fmul_func)
            FUNC_MULH: begin
                high_nx   = 1'b1;
                signed_nx = 1'b1;
            end
            FUNC_MULHU, FUNC_MULHSU: begin
                high_nx = 1'b1;
            end
            FUNC_MUL, FUNC_MULW: begin
                high_nx = 1'b0;     // low half either way.
            end
            default: begin
                high_nx = 1'b0;
            end
        endcase
    end

    // mulhsu runs unsigned on |op0| and flips the sum at the end.
    assign hsu_nx = (fmul_func == FUNC_MULHSU) & fmul_op0[`MUL_XLEN-1];
    assign op0_nx = hsu_nx ? (~fmul_op0 + 1'b1) : fmul_op0;

    // ****************************************
    // mreq stage
    // ****************************************
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            valid_q <= 1'b0;
        end else if (!fmul_stall) begin
            valid_q <= fmul_req;
        end
    end

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            high_q   <= 1'b0;
            signed_q <= 1'b0;
            hsu_q    <= 1'b0;
        end else if (load_req) begin
            high_q   <= high_nx;
            signed_q <= signed_nx;
            hsu_q    <= hsu_nx;
        end
    end

    always_ff @(posedge core_clk) begin
        if (load_req) begin
            op0_q     <= op0_nx;
            op0_neg_q <= ~op0_nx;   // saves an inverter level in the recoders.
            op1_q     <= fmul_op1;
        end
    end

    always_comb begin
        mreq.valid        = valid_q;
        mreq.high_product = high_q;
        mreq.signed_op    = signed_q;
        mreq.hsu_fix      = hsu_q;
        mreq.op0          = op0_q;
        mreq.op0_neg      = op0_neg_q;
        mreq.op1          = op1_q;
    end

    // control half of the m1 stage.
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            m1_ctrl_q <= '0;
        end else if (m1_load) begin
            m1_ctrl_q.high_product <= mreq.high_product;
            m1_ctrl_q.hsu_fix      <= mreq.hsu_fix;
        end
    end

    assign m1_ctrl = m1_ctrl_q;

endmodule

`default_nettype wire

// ==== fastmul/booth_recode.sv ====
// one radix-4 booth digit of the fast multiplier, instantiated per digit by pp_array.
`timescale 1ns/1ps
`default_nettype none

`include "mul_settings.svh"

module booth_recode (
    input  wire logic                 en,
    input  wire logic [2:0]           partial_y,
    input  wire logic                 signed_op,
    input  wire logic [`MUL_XLEN-1:0] op0,
    input  wire logic [`MUL_XLEN-1:0] op0_neg,
    output logic [`MUL_XLEN+1:0]      recode_pp,
    output logic                      cin
);
    logic                 x_sign;
    logic [`MUL_XLEN:0]   x_ext;
    logic [`MUL_XLEN:0]   xn_ext;
    logic [`MUL_XLEN+1:0] sel;

    assign x_sign = signed_op & op0[`MUL_XLEN-1];
    assign x_ext  = {x_sign, op0};
    assign xn_ext = {~x_sign, op0_neg};   // bitwise inverse of x_ext.

    always_comb begin
        sel = '0;
        if (en) begin
            case (partial_y)
                3'b001, 3'b010: sel = {x_ext[`MUL_XLEN], x_ext};     // +x
                3'b011:         sel = {x_ext, 1'b0};                 // +2x
                3'b100:         sel = {xn_ext, 1'b1};                // -2x
                3'b101, 3'b110: sel = {xn_ext[`MUL_XLEN], xn_ext};   // -x
                default:        sel = '0;
            endcase
        end
    end

    // sign bit goes out inverted, the row constants make up for it.
    assign recode_pp = {~sel[`MUL_XLEN+1], sel[`MUL_XLEN:0]};
    assign cin = en & ((partial_y == 3'b100) | (partial_y == 3'b101) | (partial_y == 3'b110));

endmodule

`default_nettype wire

// ==== fastmul/pp_array.sv ====
// partial product generation for the fast multiplier, combinational from the mreq stage.
`timescale 1ns/1ps
`default_nettype none

`include "mul_settings.svh"

module pp_array (
    input  wire mul_pkg::mreq_t mreq,
    output mul_pkg::pp_rows_t   rows
);
    import mul_pkg::*;

    logic [`MUL_XLEN:0]                         op1_ext;
    logic [`MUL_XLEN/2-1:0][`MUL_XLEN+1:0]      digit_pp;
    logic [`MUL_XLEN/2-1:0]                     digit_cin;
    logic [`MUL_PROD_W-1:0]                     cin_row;
    logic                                       corr_en;

    assign op1_ext = {mreq.op1, 1'b0};

    for (genvar i = 0; i < `MUL_XLEN/2; i++) begin : g_digit
        booth_recode u_booth_recode (
            .en        (mreq.valid),
            .partial_y (op1_ext[2*i+2:2*i]),
            .signed_op (mreq.signed_op),
            .op0       (mreq.op0),
            .op0_neg   (mreq.op0_neg),
            .recode_pp (digit_pp[i]),
            .cin       (digit_cin[i])
        );
    end

    // unsigned op1 with bit 31 set needs op0 added back at 2^32.
    assign corr_en = mreq.valid & ~mreq.signed_op & mreq.op1[`MUL_XLEN-1];

    // ****************************************
    // row placement
    // ****************************************
    always_comb begin
        cin_row = '0;
        for (int d = 0; d < `MUL_XLEN/2; d++) begin
            cin_row[2*d] = digit_cin[d];
        end
        cin_row[`MUL_XLEN+1] = 1'b1;    // lowest sign-extension constant.
        rows = '0;
        rows[0] = cin_row;
        for (int d = 0; d < `MUL_XLEN/2; d++) begin
            rows[d+1][2*d +: `MUL_XLEN+2] = digit_pp[d];
            if (d < `MUL_XLEN/2 - 1) begin
                rows[d+1][2*d+`MUL_XLEN+2] = 1'b1;
            end
        end
        rows[`MUL_XLEN/2+1] = {mreq.op0 & {`MUL_XLEN{corr_en}}, {`MUL_XLEN{1'b0}}};
        rows[`MUL_XLEN/2+2] = {`MUL_PROD_W{mreq.hsu_fix}};  // -1, so the final invert negates.
        // last row stays zero.
    end

endmodule

`default_nettype wire

// ==== fastmul/csa_42.sv ====
// 64-bit 4:2 carry-save compressor, building block of the fast multiplier tree.
`timescale 1ns/1ps
`default_nettype none

`include "mul_settings.svh"

module csa_42 (
    input  wire logic [`MUL_PROD_W-1:0] in0,
    input  wire logic [`MUL_PROD_W-1:0] in1,
    input  wire logic [`MUL_PROD_W-1:0] in2,
    input  wire logic [`MUL_PROD_W-1:0] in3,
    output logic [`MUL_PROD_W-1:0]      s,
    output logic [`MUL_PROD_W-1:0]      c
);
    logic [`MUL_PROD_W-1:0] s1;
    logic [`MUL_PROD_W-1:0] co;
    logic [`MUL_PROD_W-1:0] ci;
    logic [`MUL_PROD_W-1:0] c2;

    // first full adder level.
    assign s1 = in0 ^ in1 ^ in2;
    assign co = (in0 & in1) | (in0 & in2) | (in1 & in2);

    // lateral carry into the next bit's second level.
    assign ci = {co[`MUL_PROD_W-2:0], 1'b0};

    assign s  = s1 ^ in3 ^ ci;
    assign c2 = (s1 & in3) | (s1 & ci) | (in3 & ci);

    // carry word leaves at its own weight, bit 64 is lost.
    assign c = {c2[`MUL_PROD_W-2:0], 1'b0};

endmodule

`default_nettype wire

// ==== fastmul/csa_tree.sv ====
// reduction of the twenty partial product rows to two sum/carry pairs.
`timescale 1ns/1ps
`default_nettype none

`include "mul_settings.svh"

module csa_tree (
    input  wire mul_pkg::pp_rows_t rows,
    output mul_pkg::csa_pair_t     pair_a,
    output mul_pkg::csa_pair_t     pair_b
);
    import mul_pkg::*;

    // [chain][stage]
    wire logic [1:0][3:0][`MUL_PROD_W-1:0] st_s;
    wire logic [1:0][3:0][`MUL_PROD_W-1:0] st_c;

    for (genvar g = 0; g < 2; g++) begin : g_chain
        csa_42 u_csa_head (
            .in0 (rows[10*g]),
            .in1 (rows[10*g+1]),
            .in2 (rows[10*g+2]),
            .in3 (rows[10*g+3]),
            .s   (st_s[g][0]),
            .c   (st_c[g][0])
        );

        // each later stage folds in two new rows.
        for (genvar k = 1; k < 4; k++) begin : g_stage
            csa_42 u_csa_42 (
                .in0 (st_s[g][k-1]),
                .in1 (st_c[g][k-1]),
                .in2 (rows[10*g+2*k+2]),
                .in3 (rows[10*g+2*k+3]),
                .s   (st_s[g][k]),
                .c   (st_c[g][k])
            );
        end
    end

    assign pair_a = '{sum: st_s[0][3], carry: st_c[0][3]};    // rows 0..9.
    assign pair_b = '{sum: st_s[1][3], carry: st_c[1][3]};    // rows 10..19.

endmodule

`default_nettype wire

// ==== fastmul/mul_resolve.sv ====
// m1 stage of the fast multiplier, final add and result half select.
`timescale 1ns/1ps
`default_nettype none

`include "mul_settings.svh"

module mul_resolve (
    input  wire logic               core_clk,
    input  wire logic               core_reset_n,
    input  wire logic               m1_load,
    input  wire mul_pkg::csa_pair_t pair_a,
    input  wire mul_pkg::csa_pair_t pair_b,
    input  wire mul_pkg::m1_ctrl_t  m1_ctrl,
    output logic [`MUL_XLEN-1:0]    fmul_result
);
    import mul_pkg::*;

    csa_pair_t              pair_a_q;
    csa_pair_t              pair_b_q;
    logic [`MUL_PROD_W-1:0] prod_sum;
    logic [`MUL_PROD_W-1:0] prod_fix;

    // ****************************************
    // m1 stage registers
    // ****************************************
    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            pair_a_q <= '0;     // result reads zero out of reset.
            pair_b_q <= '0;
        end else if (m1_load) begin
            pair_a_q <= pair_a;
            pair_b_q <= pair_b;
        end
    end

    // ****************************************
    // carry-propagate add and select
    // ****************************************
    assign prod_sum = pair_a_q.sum + pair_a_q.carry + pair_b_q.sum + pair_b_q.carry;

    // mulhsu: ~(p - 1) gives -p.
    assign prod_fix = m1_ctrl.hsu_fix ? ~prod_sum : prod_sum;

    assign fmul_result = m1_ctrl.high_product ? prod_fix[`MUL_PROD_W-1:`MUL_XLEN]
                                              : prod_fix[`MUL_XLEN-1:0];

endmodule

`default_nettype wire

// ==== verilog/fastmul_top.sv ====
// top level of the fast integer multiply unit, two register stages, result after two edges.
`timescale 1ns/1ps
`default_nettype none

`include "mul_settings.svh"

module fastmul_top (
    input  wire logic                 core_clk,
    input  wire logic                 core_reset_n,
    input  wire logic                 fmul_req,
    input  wire mul_pkg::mul_func_e   fmul_func,
    input  wire logic [`MUL_XLEN-1:0] fmul_op0,
    input  wire logic [`MUL_XLEN-1:0] fmul_op1,
    input  wire logic                 fmul_stall,
    output logic [`MUL_XLEN-1:0]      fmul_result
);
    import mul_pkg::*;

    mreq_t     mreq;
    m1_ctrl_t  m1_ctrl;
    logic      m1_load;
    pp_rows_t  rows;
    csa_pair_t pair_a;
    csa_pair_t pair_b;

    mul_ctrl u_mul_ctrl (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .fmul_req     (fmul_req),
        .fmul_func    (fmul_func),
        .fmul_op0     (fmul_op0),
        .fmul_op1     (fmul_op1),
        .fmul_stall   (fmul_stall),
        .mreq         (mreq),
        .m1_ctrl      (m1_ctrl),
        .m1_load      (m1_load)
    );

    pp_array u_pp_array (
        .mreq (mreq),
        .rows (rows)
    );

    csa_tree u_csa_tree (
        .rows   (rows),
        .pair_a (pair_a),
        .pair_b (pair_b)
    );

    mul_resolve u_mul_resolve (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .m1_load      (m1_load),
        .pair_a       (pair_a),
        .pair_b       (pair_b),
        .m1_ctrl      (m1_ctrl),
        .fmul_result  (fmul_result)
    );

endmodule

`default_nettype wire

// ==== bench/fastmul_tb.sv ====
// testbench for the fast multiplier, run with list.f and fastmul_tb as the top module.
`timescale 1ns/1ps
`default_nettype none

`include "mul_settings.svh"

module fastmul_tb;
    import mul_pkg::*;

    localparam int CLK_HALF   = 50;
    localparam int WAIT_LIMIT = 64;     // edges a single wait may take.

    logic        core_clk;
    logic        core_reset_n;
    logic        fmul_req;
    mul_func_e   fmul_func;
    logic [31:0] fmul_op0;
    logic [31:0] fmul_op1;
    logic        fmul_stall;
    logic [31:0] fmul_result;
    string       req_name;

    // two-slot model of the pipeline.
    logic        mreq_v;
    logic [31:0] mreq_exp;
    string       mreq_name;
    logic [31:0] m1_exp;
    string       m1_name;
    logic        m1_new;
    logic        stall_q;
    logic [31:0] last_result;
    int          issued;
    int          checked;

    fastmul_top u_fastmul_top (
        .core_clk     (core_clk),
        .core_reset_n (core_reset_n),
        .fmul_req     (fmul_req),
        .fmul_func    (fmul_func),
        .fmul_op0     (fmul_op0),
        .fmul_op1     (fmul_op1),
        .fmul_stall   (fmul_stall),
        .fmul_result  (fmul_result)
    );

    initial begin
        core_clk = 1'b0;
        forever #CLK_HALF core_clk = ~core_clk;
    end

    // ****************************************
    // reference model
    // ****************************************
    function automatic logic [31:0] expected_result(input logic [3:0] func,
                                                    input logic [31:0] a,
                                                    input logic [31:0] b);
        logic        a_signed;
        logic        b_signed;
        logic [63:0] prod;
        a_signed = (func == `MUL_FUNC_MULH) || (func == `MUL_FUNC_MULHSU);
        b_signed = (func == `MUL_FUNC_MULH);
        prod = {{32{a_signed & a[31]}}, a} * {{32{b_signed & b[31]}}, b};
        if ((func == `MUL_FUNC_MULH) || (func == `MUL_FUNC_MULHU)
                || (func == `MUL_FUNC_MULHSU)) begin
            return prod[63:32];
        end
        return prod[31:0];
    endfunction

    function automatic logic [3:0] func_code(input int idx);
        case (idx)
            0:       return `MUL_FUNC_MUL;
            1:       return `MUL_FUNC_MULH;
            2:       return `MUL_FUNC_MULHU;
            3:       return `MUL_FUNC_MULHSU;
            default: return `MUL_FUNC_MULW;
        endcase
    endfunction

    function automatic string func_label(input logic [3:0] func);
        case (func)
            `MUL_FUNC_MUL:    return "mul";
            `MUL_FUNC_MULH:   return "mulh";
            `MUL_FUNC_MULHU:  return "mulhu";
            `MUL_FUNC_MULHSU: return "mulhsu";
            default:          return "mulw";
        endcase
    endfunction

    function automatic logic [31:0] corner_value(input int idx);
        case (idx)
            0:       return 32'h0000_0000;
            1:       return 32'h0000_0001;
            2:       return 32'hFFFF_FFFF;
            3:       return 32'h8000_0000;
            default: return 32'h7FFF_FFFF;
        endcase
    endfunction

    // mostly random words, now and then a corner.
    function automatic logic [31:0] random_operand();
        if ($urandom_range(3) == 0) begin
            return corner_value($urandom_range(4));
        end
        return $urandom;
    endfunction

    function automatic logic pick_stall(input logic allow);
        return allow && ($urandom_range(3) == 0);
    endfunction

    always @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            mreq_v  <= 1'b0;
            m1_exp  <= '0;
            m1_name <= "reset";
            m1_new  <= 1'b0;
            stall_q <= 1'b0;
        end else begin
            stall_q <= fmul_stall;
            m1_new  <= 1'b0;
            if (!fmul_stall) begin
                if (mreq_v) begin
                    m1_exp  <= mreq_exp;
                    m1_name <= mreq_name;
                    m1_new  <= 1'b1;
                end
                mreq_v <= fmul_req;
                if (fmul_req) begin
                    mreq_exp  <= expected_result(fmul_func, fmul_op0, fmul_op1);
                    mreq_name <= req_name;
                end
            end
        end
    end

    // ****************************************
    // checks, half a cycle after each edge
    // ****************************************
    always @(negedge core_clk) begin
        if (core_reset_n) begin
            if (stall_q) begin
                assert (fmul_result === last_result)
                    else report_mismatch({m1_name, " stall hold"}, last_result, fmul_result);
            end
            assert (fmul_result === m1_exp)
                else report_mismatch(m1_name, m1_exp, fmul_result);
            if (m1_new) begin
                checked = checked + 1;
            end
            last_result = fmul_result;
        end
    end

    task automatic finish_fail();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED %s: expected %h, actual %h", name, exp, act);
        finish_fail();
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        finish_fail();
    endtask

    // called right after a rising edge, returns right after the accepting edge.
    task automatic drive_request(input logic [3:0] func, input logic [31:0] a,
                                 input logic [31:0] b, input string name,
                                 input logic allow_stall);
        int   waits;
        logic accepted;
        waits    = 0;
        accepted = 1'b0;
        fmul_req   <= 1'b1;
        fmul_func  <= mul_func_e'(func);
        fmul_op0   <= a;
        fmul_op1   <= b;
        req_name   <= name;
        fmul_stall <= pick_stall(allow_stall);
        while (!accepted) begin
            @(posedge core_clk);
            if (!fmul_stall) begin
                accepted = 1'b1;
            end else begin
                waits++;
                if (waits > WAIT_LIMIT) begin
                    report_error("request was never accepted, stall held too long");
                end
                fmul_stall <= pick_stall(allow_stall);
            end
        end
        issued++;
    endtask

    task automatic idle_cycle(input logic allow_stall);
        fmul_req   <= 1'b0;
        fmul_stall <= pick_stall(allow_stall);
        @(posedge core_clk);
    endtask

    task automatic drain_pipeline();
        int waits;
        waits = 0;
        fmul_req   <= 1'b0;
        fmul_stall <= 1'b0;
        @(posedge core_clk);
        while (mreq_v) begin
            waits++;
            if (waits > WAIT_LIMIT) begin
                report_error("pipeline did not drain");
            end
            @(posedge core_clk);
        end
    endtask

    initial begin
        logic [3:0] func;
        void'($urandom(37));
        core_reset_n = 1'b0;
        fmul_req     = 1'b0;
        fmul_func    = FUNC_MUL;
        fmul_op0     = '0;
        fmul_op1     = '0;
        fmul_stall   = 1'b0;
        req_name     = "idle";
        last_result  = '0;
        issued       = 0;
        checked      = 0;
        repeat (2) @(posedge core_clk);
        core_reset_n <= 1'b1;
        repeat (3) @(posedge core_clk);     // result must read zero here.

        // corner operands, back to back.
        for (int f = 0; f < 5; f++) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    func = func_code(f);
                    drive_request(func, corner_value(i), corner_value(j),
                                  {"corner ", func_label(func)}, 1'b0);
                end
            end
        end

        for (int n = 0; n < 200; n++) begin
            func = func_code($urandom_range(4));
            drive_request(func, random_operand(), random_operand(),
                          {"random ", func_label(func)}, 1'b0);
        end

        // random stalls and gaps in the stream.
        for (int n = 0; n < 300; n++) begin
            if ($urandom_range(3) == 0) begin
                idle_cycle(1'b1);
            end
            func = func_code($urandom_range(4));
            drive_request(func, random_operand(), random_operand(),
                          {"stall ", func_label(func)}, 1'b1);
        end

        drain_pipeline();
        @(negedge core_clk);
        if ((issued > 0) && (checked == issued)) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            report_error($sformatf("%0d requests issued, %0d results seen", issued, checked));
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/mul_pkg.sv
fastmul/mul_ctrl.sv
fastmul/booth_recode.sv
fastmul/pp_array.sv
fastmul/csa_42.sv
fastmul/csa_tree.sv
fastmul/mul_resolve.sv
verilog/fastmul_top.sv
bench/fastmul_tb.sv
